// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= host_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

# Build and run, pass only if the testbench prints its pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/host_assert.sv
/*
 * Host device handshake assertions
 * Bound to host_top, checks response hold, ready/valid exclusion and reset
 */

`default_nettype none

module host_assert
  (input logic                 clk_i
  ,input logic                 rst_i
  ,input logic                 cmd_ready_i
  ,input logic                 resp_v_i
  ,input logic                 resp_ready_i
  ,input host_pkg::host_resp_s resp_i
  );

  // A waiting response keeps its valid and its contents
  resp_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
    (resp_v_i && !resp_ready_i) |=> (resp_v_i && $stable(resp_i)))
    else $error("response valid dropped or response changed under back-pressure");

  // Only one command in flight
  one_in_flight_a: assert property (@(posedge clk_i) disable iff (rst_i)
    !(cmd_ready_i && resp_v_i))
    else $error("command ready and response valid high together");

  reset_quiet_a: assert property (@(posedge clk_i) rst_i |=> !resp_v_i)
    else $error("response valid high while in reset");

endmodule

bind host_top host_assert handshake_chk
  (.clk_i        (clk_i)
  ,.rst_i        (rst_i)
  ,.cmd_ready_i  (cmd_ready_o)
  ,.resp_v_i     (resp_v_o)
  ,.resp_ready_i (resp_ready_i)
  ,.resp_i       (resp_o)
  );

`default_nettype wire

// File: bench/host_tb.sv
/*
 * Host device testbench
 * Runs a table of single-beat commands through host_top and checks each
 * response and the trace and finish levels, with random response back-pressure
 */

`default_nettype none

`include "host_macros.svh"

module host_tb;

  import host_pkg::*;

  localparam int          clk_period_lp  = 100;
  localparam int          drive_delay_lp = 10;
  localparam int          reset_cycles_lp = 10;
  localparam logic [31:0] lfsr_poly_lp   = 32'hD000_0001;
  localparam logic [`HOST_TRACE_N-1:0] allowed_lp = `HOST_TRACE_ALLOWED;

  // One table entry with the command and the levels expected after it
  typedef struct packed {
    host_cmd_s                  cmd;
    logic [`HOST_DATA_W-1:0]    exp_data;
    logic [`HOST_TRACE_N-1:0]   exp_trace;
    logic [`HOST_NUM_CORES-1:0] exp_finish;
    logic                       exp_all;
  } entry_s;

  logic                       clk;
  logic                       rst;
  host_cmd_s                  cmd;
  logic                       cmd_v;
  logic                       cmd_ready;
  host_resp_s                 resp;
  logic                       resp_v;
  logic                       resp_ready;
  trace_en_s                  trace_en;
  logic [`HOST_NUM_CORES-1:0] finish;
  logic                       all_finish;

  entry_s                     stim_q [$];
  logic [`HOST_TRACE_N-1:0]   model_trace;
  logic [`HOST_NUM_CORES-1:0] model_finish;
  logic [31:0]                lfsr;
  logic                       table_built = 1'b0;
  logic                       resp_pending = 1'b0;
  int                         n_checks = 0;
  int                         n_errors = 0;
  int                         n_resp = 0;
  int                         cur_entry = -1;

  host_top uut
    (.clk_i        (clk)
    ,.rst_i        (rst)
    ,.cmd_i        (cmd)
    ,.cmd_v_i      (cmd_v)
    ,.cmd_ready_o  (cmd_ready)
    ,.resp_o       (resp)
    ,.resp_v_o     (resp_v)
    ,.resp_ready_i (resp_ready)
    ,.trace_en_o   (trace_en)
    ,.finish_o     (finish)
    ,.all_finish_o (all_finish)
    );

  initial begin
    clk = 1'b0;
    forever #(clk_period_lp / 2) clk = ~clk;
  end

  // Each response counts once at the first edge where its valid is seen
  always @(posedge clk) begin
    if (rst) begin
      resp_pending <= 1'b0;
    end else begin
      if (resp_v && !resp_pending) begin
        n_resp <= n_resp + 1;
      end
      resp_pending <= resp_v && !resp_ready;
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? lfsr_poly_lp : 32'h0);
  endfunction

  // Two LFSR bits give a hold-off of 0 to 3 cycles
  function automatic logic [1:0] random_gap();
    logic [1:0] g;
    g = 2'b00;
    for (int b = 0; b < 2; b++) begin
      g = {g[0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return g;
  endfunction

  task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Error: %s = 0x%0h, expected 0x%0h (entry %0d, time %0t)",
               name, got, exp, cur_entry, $time);
    end
  endtask

  // Appends one command and works out its response from the device rules
  task automatic add_entry(input host_msg_e msg, input logic [3:0] dev,
                           input logic [3:0] low, input logic [63:0] data);
    entry_s e;
    e.cmd.msg  = msg;
    e.cmd.addr = {dev, 12'(stim_q.size() * 37), low};
    e.cmd.data = data;
    e.exp_data = '0;
    if (dev == `HOST_DEV_TRACE && low < 4'd12) begin
      if (msg == e_host_wr) begin
        model_trace[low] = data[0];
      end else begin
        e.exp_data[0] = model_trace[low] & allowed_lp[low];
      end
    end else if (dev == `HOST_DEV_FINISH) begin
      if (msg == e_host_wr) begin
        model_finish[low[1:0]] = 1'b1;
      end else begin
        e.exp_data[0] = model_finish[low[1:0]];
      end
    end
    e.exp_trace  = model_trace & allowed_lp;
    e.exp_finish = model_finish;
    e.exp_all    = &model_finish;
    stim_q.push_back(e);
  endtask

  task automatic build_table();
    model_trace  = '0;
    model_finish = '0;
    // Every trace index reads zero out of reset
    for (int i = 0; i < 16; i++) begin
      add_entry(e_host_rd, `HOST_DEV_TRACE, 4'(i), 64'h5a5a);
    end
    // Set every index including the four past the last enable
    for (int i = 0; i < 16; i++) begin
      add_entry(e_host_wr, `HOST_DEV_TRACE, 4'(i), 64'hfeed_0000_0000_0001);
      add_entry(e_host_rd, `HOST_DEV_TRACE, 4'(i), 64'h0);
    end
    // Clear the even ones with only data bit 0 low
    for (int i = 0; i < 12; i += 2) begin
      add_entry(e_host_wr, `HOST_DEV_TRACE, 4'(i), 64'hffff_ffff_ffff_fffe);
      add_entry(e_host_rd, `HOST_DEV_TRACE, 4'(i), 64'h0);
    end
    add_entry(e_host_wr, 4'd0, 4'd3, 64'h1);
    add_entry(e_host_rd, 4'd0, 4'd3, 64'hffff);
    add_entry(e_host_wr, 4'd3, 4'd1, 64'h1);
    add_entry(e_host_rd, 4'd15, 4'd0, 64'h1);
    // Finish each core in turn with padding bits set on the writes
    for (int i = 0; i < `HOST_NUM_CORES; i++) begin
      add_entry(e_host_rd, `HOST_DEV_FINISH, 4'(i), 64'h0);
      add_entry(e_host_wr, `HOST_DEV_FINISH, {2'b11, 2'(i)}, 64'(i));
      add_entry(e_host_rd, `HOST_DEV_FINISH, 4'(i), 64'h0);
    end
    add_entry(e_host_wr, 4'd15, 4'd1, '1);
    add_entry(e_host_rd, 4'd7, 4'd2, 64'h0);
    for (int i = 0; i < 12; i++) begin
      add_entry(e_host_rd, `HOST_DEV_TRACE, 4'(i), 64'h0);
    end
  endtask

  task automatic run_entry(input int n);
    entry_s     e;
    host_resp_s held;
    logic [1:0] gap;
    e = stim_q[n];
    cur_entry = n;
    while (!cmd_ready) begin
      @(posedge clk);
      #drive_delay_lp;
    end
    cmd   = e.cmd;
    cmd_v = 1'b1;
    @(posedge clk);
    #drive_delay_lp;
    cmd_v = 1'b0;
    cmd   = '0;
    while (!resp_v) begin
      @(posedge clk);
      #drive_delay_lp;
    end
    check("resp_o.msg", 128'(resp.msg), 128'(e.cmd.msg));
    check("resp_o.addr", 128'(resp.addr), 128'(e.cmd.addr));
    check("resp_o.data", 128'(resp.data), 128'(e.exp_data));
    check("trace_en_o", 128'(trace_en), 128'(e.exp_trace));
    check("finish_o", 128'(finish), 128'(e.exp_finish));
    check("all_finish_o", 128'(all_finish), 128'(e.exp_all));
    held = resp;
    gap  = random_gap();
    repeat (gap) begin
      @(posedge clk);
      #drive_delay_lp;
      check("resp_v_o", 128'(resp_v), 128'd1);
      check("cmd_ready_o", 128'(cmd_ready), 128'd0);
      check("resp_o", 128'(resp), 128'(held));
    end
    resp_ready = 1'b1;
    @(posedge clk);
    #drive_delay_lp;
    resp_ready = 1'b0;
    check("resp_v_o", 128'(resp_v), 128'd0);
    check("cmd_ready_o", 128'(cmd_ready), 128'd1);
  endtask

  initial begin
    rst        = 1'b1;
    cmd        = '0;
    cmd_v      = 1'b0;
    resp_ready = 1'b0;
    lfsr       = 32'd69044;
    build_table();
    table_built = 1'b1;
    repeat (reset_cycles_lp) @(posedge clk);
    #drive_delay_lp;
    rst = 1'b0;
    @(posedge clk);
    #drive_delay_lp;
    // Levels out of reset before any command
    check("cmd_ready_o", 128'(cmd_ready), 128'd1);
    check("resp_v_o", 128'(resp_v), 128'd0);
    check("trace_en_o", 128'(trace_en), 128'd0);
    check("finish_o", 128'(finish), 128'd0);
    check("all_finish_o", 128'(all_finish), 128'd0);
    for (int n = 0; n < stim_q.size(); n++) begin
      run_entry(n);
    end
    check("response count", 128'(n_resp), 128'(stim_q.size()));
    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Ten cycles per table entry plus reset is far more than a command needs
  initial begin
    int limit_cycles;
    wait (table_built);
    limit_cycles = stim_q.size() * 10 + 2 * reset_cycles_lp;
    #(limit_cycles * clk_period_lp);
    $display("Timeout: the table did not complete within %0d cycles", limit_cycles);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/finish_tracker.sv
/*
 * Finish tracker
 * Sticky finish flag per core and the all-finished level
 */

`default_nettype none

`include "host_macros.svh"

module finish_tracker
  (input  logic                       clk_i
  ,input  logic                       rst_i

  ,input  logic                       wr_i
  ,input  host_pkg::host_cmd_s        cmd_i

  ,output logic [`HOST_NUM_CORES-1:0] finish_o
  ,output logic                       all_finish_o
  ,output logic                       rd_bit_o
  );

  import host_pkg::*;

  logic [`HOST_NUM_CORES-1:0] finish_r;
  logic [`HOST_CORE_W-1:0]    core;

  assign core = cmd_i.addr.finish.core;

  assign finish_o     = finish_r;
  assign all_finish_o = &finish_r;
  assign rd_bit_o     = finish_r[core];

  // Any write marks the core done, data is ignored
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      finish_r <= '0;
    end else if (wr_i) begin
      finish_r[core] <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: rtl/host_ctrl.sv
/*
 * Host command control
 * Idle/respond FSM for single-beat commands, device decode into
 * write strobes and the read select, response valid held until taken
 */

`default_nettype none

`include "host_macros.svh"

module host_ctrl
  (input  logic                clk_i
  ,input  logic                rst_i

  ,input  host_pkg::host_cmd_s cmd_i
  ,input  logic                cmd_v_i
  ,output logic                cmd_ready_o

  ,output logic                resp_v_o
  ,input  logic                resp_ready_i

  ,output logic                trace_wr_o
  ,output logic                finish_wr_o
  ,output logic                capture_o
  // Bit 0 selects the trace read-back, bit 1 the finish read-back
  ,output logic [1:0]          rd_sel_o
  );

  import host_pkg::*;

  typedef enum logic {
    e_idle = 1'b0,
    e_resp = 1'b1
  } state_e;

  state_e state_r, state_n;

  logic                  accept;
  logic                  is_wr;
  logic                  is_trace;
  logic                  is_finish;
  logic [`HOST_DEV_W-1:0] dev;

  assign cmd_ready_o = (state_r == e_idle);
  assign resp_v_o    = (state_r == e_resp);

  assign accept = cmd_v_i & cmd_ready_o;

  // Both address views share the device field
  assign dev       = cmd_i.addr.trace.dev;
  assign is_trace  = (dev == `HOST_DEV_TRACE);
  assign is_finish = (dev == `HOST_DEV_FINISH);
  assign is_wr     = (cmd_i.msg == e_host_wr);

  assign trace_wr_o  = accept & is_wr & is_trace;
  assign finish_wr_o = accept & is_wr & is_finish;
  assign capture_o   = accept;

  // Unknown devices select nothing and so read back zero
  assign rd_sel_o = {is_finish, is_trace};

  always_comb begin
    state_n = state_r;
    case (state_r)
      e_idle: begin
        if (accept) begin
          state_n = e_resp;
        end
      end
      e_resp: begin
        if (resp_ready_i) begin
          state_n = e_idle;
        end
      end
      default: state_n = e_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r <= e_idle;
    end else begin
      state_r <= state_n;
    end
  end

endmodule

`default_nettype wire

// File: rtl/host_macros.svh
/*
 * Host device build constants
 * Widths, core count, device codes and the mask of traces this build permits
 */

`ifndef HOST_MACROS_SVH
`define HOST_MACROS_SVH

`define HOST_DATA_W 64
`define HOST_ADDR_W 20

// Device code lives in the top bits of the address
`define HOST_DEV_W 4

`define HOST_NUM_CORES 4
`define HOST_CORE_W 2

`define HOST_TRACE_N 12

`define HOST_DEV_TRACE 4'd1
`define HOST_DEV_FINISH 4'd2

// Bit i permits trace enable i (icache is bit 0, device trace is bit 11)
`define HOST_TRACE_ALLOWED 12'b1010_0111_1011

`endif

// File: rtl/host_pkg.sv
/*
 * Host device types
 * Message type, command and response words, the two views of the
 * command address and the named trace enables
 */

`default_nettype none

`include "host_macros.svh"

package host_pkg;

  typedef enum logic {
    e_host_rd = 1'b0,
    e_host_wr = 1'b1
  } host_msg_e;

  // Trace region address: device, padding, enable index
  typedef struct packed {
    logic [`HOST_DEV_W-1:0]                                 dev;
    logic [`HOST_ADDR_W-`HOST_DEV_W-$clog2(`HOST_TRACE_N)-1:0] pad;
    logic [$clog2(`HOST_TRACE_N)-1:0]                       idx;
  } host_trace_addr_s;

  // Finish region address: device, padding, core index
  typedef struct packed {
    logic [`HOST_DEV_W-1:0]                         dev;
    logic [`HOST_ADDR_W-`HOST_DEV_W-`HOST_CORE_W-1:0] pad;
    logic [`HOST_CORE_W-1:0]                        core;
  } host_finish_addr_s;

  typedef union packed {
    host_trace_addr_s  trace;
    host_finish_addr_s finish;
  } host_addr_u;

  typedef struct packed {
    host_msg_e               msg;
    host_addr_u              addr;
    logic [`HOST_DATA_W-1:0] data;
  } host_cmd_s;

  typedef struct packed {
    host_msg_e               msg;
    host_addr_u              addr;
    logic [`HOST_DATA_W-1:0] data;
  } host_resp_s;

  // First field is the MSB, so icache sits at enable index 0
  typedef struct packed {
    logic dev;
    logic cosim;
    logic branch_profile;
    logic pc_profile;
    logic core_profile;
    logic cmt;
    logic vm;
    logic dram;
    logic cce;
    logic lce;
    logic dcache;
    logic icache;
  } trace_en_s;

endpackage

`default_nettype wire

// File: rtl/host_resp_reg.sv
/*
 * Host response register
 * Captures message type, address and read data on accept and holds
 * them while the response waits for ready
 */

`default_nettype none

`include "host_macros.svh"

module host_resp_reg
  (input  logic                 clk_i
  ,input  logic                 rst_i

  ,input  logic                 capture_i
  ,input  host_pkg::host_cmd_s  cmd_i
  ,input  logic [1:0]           rd_sel_i

  ,input  logic                 trace_bit_i
  ,input  logic                 finish_bit_i

  ,output host_pkg::host_resp_s resp_o
  );

  import host_pkg::*;

  host_resp_s resp_r;
  logic       rd_bit;

  // At most one select is set, none for an unknown device
  assign rd_bit = (rd_sel_i[0] & trace_bit_i) | (rd_sel_i[1] & finish_bit_i);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      resp_r <= '0;
    end else if (capture_i) begin
      resp_r.msg  <= cmd_i.msg;
      resp_r.addr <= cmd_i.addr;
      if (cmd_i.msg == e_host_rd) begin
        resp_r.data <= {{(`HOST_DATA_W-1){1'b0}}, rd_bit};
      end else begin
        resp_r.data <= '0;
      end
    end
  end

  assign resp_o = resp_r;

endmodule

`default_nettype wire

// File: rtl/host_top.sv
/*
 * Host device top
 * Command control plus trace enables, finish tracking and the
 * response register
 */

`default_nettype none

`include "host_macros.svh"

module host_top
  (input  logic                       clk_i
  ,input  logic                       rst_i

  ,input  host_pkg::host_cmd_s        cmd_i
  ,input  logic                       cmd_v_i
  ,output logic                       cmd_ready_o

  ,output host_pkg::host_resp_s       resp_o
  ,output logic                       resp_v_o
  ,input  logic                       resp_ready_i

  ,output host_pkg::trace_en_s        trace_en_o
  ,output logic [`HOST_NUM_CORES-1:0] finish_o
  ,output logic                       all_finish_o
  );

  logic       trace_wr;
  logic       finish_wr;
  logic       capture;
  logic [1:0] rd_sel;
  logic       trace_bit;
  logic       finish_bit;

  host_ctrl ctrl
    (.clk_i        (clk_i)
    ,.rst_i        (rst_i)
    ,.cmd_i        (cmd_i)
    ,.cmd_v_i      (cmd_v_i)
    ,.cmd_ready_o  (cmd_ready_o)
    ,.resp_v_o     (resp_v_o)
    ,.resp_ready_i (resp_ready_i)
    ,.trace_wr_o   (trace_wr)
    ,.finish_wr_o  (finish_wr)
    ,.capture_o    (capture)
    ,.rd_sel_o     (rd_sel)
    );

  trace_enable_regs trace_regs
    (.clk_i      (clk_i)
    ,.rst_i      (rst_i)
    ,.wr_i       (trace_wr)
    ,.cmd_i      (cmd_i)
    ,.trace_en_o (trace_en_o)
    ,.rd_bit_o   (trace_bit)
    );

  finish_tracker finish
    (.clk_i        (clk_i)
    ,.rst_i        (rst_i)
    ,.wr_i         (finish_wr)
    ,.cmd_i        (cmd_i)
    ,.finish_o     (finish_o)
    ,.all_finish_o (all_finish_o)
    ,.rd_bit_o     (finish_bit)
    );

  host_resp_reg resp_reg
    (.clk_i        (clk_i)
    ,.rst_i        (rst_i)
    ,.capture_i    (capture)
    ,.cmd_i        (cmd_i)
    ,.rd_sel_i     (rd_sel)
    ,.trace_bit_i  (trace_bit)
    ,.finish_bit_i (finish_bit)
    ,.resp_o       (resp_o)
    );

endmodule

`default_nettype wire

// File: rtl/trace_enable_regs.sv
/*
 * Trace enable registers
 * Twelve enable flags written by index, gated by the allowed-trace mask
 */

`default_nettype none

`include "host_macros.svh"

module trace_enable_regs
  (input  logic                clk_i
  ,input  logic                rst_i

  ,input  logic                wr_i
  ,input  host_pkg::host_cmd_s cmd_i

  ,output host_pkg::trace_en_s trace_en_o
  ,output logic                rd_bit_o
  );

  import host_pkg::*;

  localparam int idx_w_lp = $clog2(`HOST_TRACE_N);

  logic [`HOST_TRACE_N-1:0]  en_r;
  logic [`HOST_TRACE_N-1:0]  en_gated;
  logic [(1<<idx_w_lp)-1:0]  rd_vec;
  logic [idx_w_lp-1:0]       idx;

  assign idx = cmd_i.addr.trace.idx;

  // A disallowed trace never shows, whatever was written
  assign en_gated   = en_r & `HOST_TRACE_ALLOWED;
  assign trace_en_o = trace_en_s'(en_gated);

  // Indices past the last enable read as zero
  assign rd_vec   = {{((1<<idx_w_lp)-`HOST_TRACE_N){1'b0}}, en_gated};
  assign rd_bit_o = rd_vec[idx];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      en_r <= '0;
    end else if (wr_i && (idx < `HOST_TRACE_N)) begin
      en_r[idx] <= cmd_i.data[0];
    end
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+rtl
rtl/host_pkg.sv
rtl/host_ctrl.sv
rtl/trace_enable_regs.sv
rtl/finish_tracker.sv
rtl/host_resp_reg.sv
rtl/host_top.sv
bench/host_assert.sv
bench/host_tb.sv
